// File: rtl/hci_settings.svh
// *********************************************************
// Widths, queue depth and register map of the HCI PIO core
// *********************************************************
`ifndef HCI_SETTINGS_SVH
`define HCI_SETTINGS_SVH

`define HCI_DW    32
`define HCI_AW    4
`define HCI_DEPTH 8
`define HCI_CW    4   // Holds 0 to HCI_DEPTH

// Register word addresses
`define HCI_A_RESET  0
`define HCI_A_THLD   1
`define HCI_A_CMD    2
`define HCI_A_RESP   3
`define HCI_A_STATUS 4

`define HCI_THLD_CQ_LSB 0   // Command empty-space threshold
`define HCI_THLD_RQ_LSB 8   // Response fill threshold

`endif

// File: rtl/hci_pkg.sv
// *********************************************************
// Shared types of the HCI PIO core, imported by RTL and TB
// *********************************************************
package hci_pkg;

  `include "hci_settings.svh"

  // Data word on CPU port and both streams
  typedef logic [`HCI_DW-1:0] dword_t;

  typedef logic [`HCI_AW-1:0] csr_addr_t;

  // Queue fill count or threshold
  typedef logic [`HCI_CW-1:0] qcnt_t;

  typedef enum logic [1:0] {
    CSR_IDLE,
    CSR_PORT_WAIT,  // Stalled on a queue
    CSR_ACK
  } csr_state_e;

endpackage

// File: rtl/hci_queue.sv
// *********************************************************
// Circular queue with clamped threshold trigger and flush
// *********************************************************
`timescale 1ns/100ps
`include "hci_settings.svh"

module hci_queue
  import hci_pkg::*;
#(
  parameter bit TrigOnFree = 1'b0  // Trigger on free entries instead of filled ones
) (
  input  logic   clk_i,
  input  logic   rst_ni,

  input  logic   push_valid_i,
  output logic   push_ready_o,
  input  dword_t push_data_i,

  output logic   pop_valid_o,
  input  logic   pop_ready_i,
  output dword_t pop_data_o,

  input  qcnt_t  thld_i,
  output qcnt_t  thld_o,
  output logic   trig_o,
  output logic   full_o,
  output logic   empty_o,

  input  logic   flush_i,
  output logic   flush_done_o
);
  localparam int unsigned PtrW = $clog2(`HCI_DEPTH);
  localparam qcnt_t Depth = qcnt_t'(`HCI_DEPTH);

  dword_t          mem_q [`HCI_DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  qcnt_t           count_q;
  qcnt_t           trig_cnt;
  logic            push;
  logic            pop;
  logic            flush_done_q;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(`HCI_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o       = (count_q == Depth);
  assign empty_o      = (count_q == '0);
  assign push_ready_o = ~full_o;
  assign pop_valid_o  = ~empty_o;
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  // Programmed value never exceeds the depth
  assign thld_o   = (thld_i > Depth) ? Depth : thld_i;
  assign trig_cnt = TrigOnFree ? (Depth - count_q) : count_q;
  assign trig_o   = (trig_cnt >= thld_o);  // Zero threshold always fires

  assign flush_done_o = flush_done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      flush_done_q <= 1'b0;
    end else begin
      flush_done_q <= flush_i & ~flush_done_q;  // One pulse per request
      if (flush_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
        if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
        if (push && !pop) begin
          count_q <= count_q + 1'b1;
        end else if (pop && !push) begin
          count_q <= count_q - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

// File: rtl/hci_csr.sv
// *********************************************************
// Register file behind the req/ack CPU port; stalls port
// accesses until the command or response queue is ready
// *********************************************************
`timescale 1ns/100ps
`include "hci_settings.svh"

module hci_csr
  import hci_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      cpu_req_i,
  input  logic      cpu_wr_i,
  input  csr_addr_t cpu_addr_i,
  input  dword_t    cpu_wdata_i,
  output logic      cpu_ack_o,
  output logic      cpu_err_o,
  output dword_t    cpu_rdata_o,

  output logic      cq_push_valid_o,
  input  logic      cq_push_ready_i,
  output dword_t    cq_push_data_o,
  output qcnt_t     cq_thld_o,
  input  qcnt_t     cq_thld_i,
  input  logic      cq_full_i,
  input  logic      cq_empty_i,
  input  logic      cq_trig_i,
  output logic      cq_flush_o,
  input  logic      cq_flush_done_i,

  input  logic      rq_pop_valid_i,
  output logic      rq_pop_ready_o,
  input  dword_t    rq_pop_data_i,
  output qcnt_t     rq_thld_o,
  input  qcnt_t     rq_thld_i,
  input  logic      rq_full_i,
  input  logic      rq_empty_i,
  input  logic      rq_trig_i,
  output logic      rq_flush_o,
  input  logic      rq_flush_done_i
);
  csr_state_e state_q;
  logic       ack_q;
  logic       err_q;
  logic [1:0] rst_q;      // Bit 0 command, bit 1 response
  logic [1:0] rst_set;
  qcnt_t      cq_thld_q;
  qcnt_t      rq_thld_q;
  dword_t     rdata_q;
  dword_t     reg_rdata;
  logic       reg_err;
  logic       accept;
  logic       port_acc;
  logic       reg_we;
  logic       cq_push;
  logic       rq_pop;

  // Ack cycle blocks a new accept while req is still up
  assign accept   = (state_q == CSR_IDLE) && cpu_req_i && !ack_q;
  assign port_acc = (cpu_wr_i && cpu_addr_i == csr_addr_t'(`HCI_A_CMD)) ||
                    (!cpu_wr_i && cpu_addr_i == csr_addr_t'(`HCI_A_RESP));
  assign reg_we   = accept && cpu_wr_i && !port_acc;

  assign cq_push_valid_o = (state_q == CSR_PORT_WAIT) && cpu_wr_i;
  assign cq_push_data_o  = cpu_wdata_i;
  assign rq_pop_ready_o  = (state_q == CSR_PORT_WAIT) && !cpu_wr_i;
  assign cq_push = cq_push_valid_o & cq_push_ready_i;
  assign rq_pop  = rq_pop_ready_o & rq_pop_valid_i;

  always_comb begin
    reg_rdata = '0;
    reg_err   = 1'b0;
    case (cpu_addr_i)
      csr_addr_t'(`HCI_A_RESET): reg_rdata[1:0] = rst_q;
      csr_addr_t'(`HCI_A_THLD): begin
        reg_rdata[`HCI_THLD_CQ_LSB +: `HCI_CW] = cq_thld_i;  // Clamped values
        reg_rdata[`HCI_THLD_RQ_LSB +: `HCI_CW] = rq_thld_i;
      end
      csr_addr_t'(`HCI_A_CMD), csr_addr_t'(`HCI_A_RESP): reg_rdata = '0;
      csr_addr_t'(`HCI_A_STATUS): begin
        reg_rdata[5:0] = {rq_trig_i, cq_trig_i, rq_empty_i, rq_full_i, cq_empty_i, cq_full_i};
      end
      default: reg_err = 1'b1;
    endcase
  end

  assign rst_set = (reg_we && cpu_addr_i == csr_addr_t'(`HCI_A_RESET)) ? cpu_wdata_i[1:0] : 2'b00;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_q     <= '0;
      cq_thld_q <= '0;
      rq_thld_q <= '0;
    end else begin
      rst_q <= (rst_q & ~{rq_flush_done_i, cq_flush_done_i}) | rst_set;
      if (reg_we && cpu_addr_i == csr_addr_t'(`HCI_A_THLD)) begin
        cq_thld_q <= cpu_wdata_i[`HCI_THLD_CQ_LSB +: `HCI_CW];
        rq_thld_q <= cpu_wdata_i[`HCI_THLD_RQ_LSB +: `HCI_CW];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CSR_IDLE;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      case (state_q)
        CSR_IDLE: begin
          if (accept) begin
            err_q   <= reg_err;
            state_q <= port_acc ? CSR_PORT_WAIT : CSR_ACK;
          end
        end
        CSR_PORT_WAIT: begin
          if (cq_push || rq_pop) begin
            ack_q   <= 1'b1;
            state_q <= CSR_IDLE;
          end
        end
        CSR_ACK: begin
          ack_q   <= 1'b1;
          state_q <= CSR_IDLE;
        end
        default: state_q <= CSR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rq_pop) begin
      rdata_q <= rq_pop_data_i;
    end else if (accept && !port_acc) begin
      rdata_q <= reg_rdata;
    end
  end

  assign cpu_ack_o   = ack_q;
  assign cpu_err_o   = ack_q & err_q;
  assign cpu_rdata_o = rdata_q;
  assign cq_thld_o   = cq_thld_q;
  assign rq_thld_o   = rq_thld_q;
  assign cq_flush_o  = rst_q[0];
  assign rq_flush_o  = rst_q[1];

endmodule

// File: rtl/hci_top.sv
// *********************************************************
// HCI PIO core top: register file plus command and response
// queues, controller streams and threshold triggers
// *********************************************************
`timescale 1ns/100ps

module hci_top
  import hci_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      cpu_req_i,
  input  logic      cpu_wr_i,
  input  csr_addr_t cpu_addr_i,
  input  dword_t    cpu_wdata_i,
  output logic      cpu_ack_o,
  output logic      cpu_err_o,
  output dword_t    cpu_rdata_o,

  output logic      cmd_valid_o,
  input  logic      cmd_ready_i,
  output dword_t    cmd_data_o,

  input  logic      resp_valid_i,
  output logic      resp_ready_o,
  input  dword_t    resp_data_i,

  output logic      cmd_thld_trig_o,
  output logic      resp_thld_trig_o
);
  logic   cq_push_valid, cq_push_ready, cq_full, cq_empty, cq_flush, cq_flush_done;
  logic   rq_pop_valid, rq_pop_ready, rq_full, rq_empty, rq_flush, rq_flush_done;
  dword_t cq_push_data, rq_pop_data;
  qcnt_t  cq_thld_raw, cq_thld_eff, rq_thld_raw, rq_thld_eff;

  hci_csr u_csr (
    .clk_i, .rst_ni,
    .cpu_req_i, .cpu_wr_i, .cpu_addr_i, .cpu_wdata_i,
    .cpu_ack_o, .cpu_err_o, .cpu_rdata_o,
    .cq_push_valid_o(cq_push_valid), .cq_push_ready_i(cq_push_ready),
    .cq_push_data_o(cq_push_data), .cq_thld_o(cq_thld_raw), .cq_thld_i(cq_thld_eff),
    .cq_full_i(cq_full), .cq_empty_i(cq_empty), .cq_trig_i(cmd_thld_trig_o),
    .cq_flush_o(cq_flush), .cq_flush_done_i(cq_flush_done),
    .rq_pop_valid_i(rq_pop_valid), .rq_pop_ready_o(rq_pop_ready),
    .rq_pop_data_i(rq_pop_data), .rq_thld_o(rq_thld_raw), .rq_thld_i(rq_thld_eff),
    .rq_full_i(rq_full), .rq_empty_i(rq_empty), .rq_trig_i(resp_thld_trig_o),
    .rq_flush_o(rq_flush), .rq_flush_done_i(rq_flush_done)
  );

  // Command queue fires on free space
  hci_queue #(.TrigOnFree(1'b1)) u_cmd_q (
    .clk_i, .rst_ni,
    .push_valid_i(cq_push_valid), .push_ready_o(cq_push_ready), .push_data_i(cq_push_data),
    .pop_valid_o(cmd_valid_o), .pop_ready_i(cmd_ready_i), .pop_data_o(cmd_data_o),
    .thld_i(cq_thld_raw), .thld_o(cq_thld_eff), .trig_o(cmd_thld_trig_o),
    .full_o(cq_full), .empty_o(cq_empty),
    .flush_i(cq_flush), .flush_done_o(cq_flush_done)
  );

  hci_queue #(.TrigOnFree(1'b0)) u_resp_q (
    .clk_i, .rst_ni,
    .push_valid_i(resp_valid_i), .push_ready_o(resp_ready_o), .push_data_i(resp_data_i),
    .pop_valid_o(rq_pop_valid), .pop_ready_i(rq_pop_ready), .pop_data_o(rq_pop_data),
    .thld_i(rq_thld_raw), .thld_o(rq_thld_eff), .trig_o(resp_thld_trig_o),
    .full_o(rq_full), .empty_o(rq_empty),
    .flush_i(rq_flush), .flush_done_o(rq_flush_done)
  );

endmodule

// File: sim/hci_props.sv
// *********************************************************
// Handshake and status assertions, bound into hci_top
// *********************************************************
`timescale 1ns/100ps
`include "hci_settings.svh"

module hci_props (
  input logic clk_i,
  input logic rst_ni,
  input logic cpu_ack_o,
  input logic cmd_valid_o,
  input logic cmd_ready_i,
  input logic cq_flush,
  input logic resp_valid_i,
  input logic resp_ready_o,
  input logic rq_pop_valid,
  input logic rq_pop_ready,
  input logic rq_flush
);
  logic resp_in;
  logic resp_out;
  int   resp_cnt;  // Response entries held, counted from the handshakes

  assign resp_in  = resp_valid_i & resp_ready_o;
  assign resp_out = rq_pop_valid & rq_pop_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_cnt <= 0;
    end else if (rq_flush) begin
      resp_cnt <= 0;
    end else begin
      resp_cnt <= resp_cnt + int'(resp_in) - int'(resp_out);
    end
  end

  // Ack is a single cycle pulse
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cpu_ack_o |=> !cpu_ack_o) else $error("cpu_ack_o high two cycles in a row");

  cmd_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o && !cmd_ready_i && !cq_flush |=> cmd_valid_o)
    else $error("cmd_valid_o dropped without a transfer");

  resp_full_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_ready_o == (resp_cnt < `HCI_DEPTH))
    else $error("resp_ready_o does not follow the response queue fill");

endmodule

bind hci_top hci_props u_props (.*);

// File: sim/hci_tb.sv
// *********************************************************
// Testbench for hci_top, driven by the vectors in hci_tests.txt
// *********************************************************
`timescale 1ns/100ps
`include "hci_settings.svh"

module hci_tb;
  import hci_pkg::*;

  logic      clk_i = 1'b0;
  logic      rst_ni = 1'b0;
  logic      cpu_req_i = 1'b0;
  logic      cpu_wr_i = 1'b0;
  csr_addr_t cpu_addr_i = '0;
  dword_t    cpu_wdata_i = '0;
  logic      cpu_ack_o, cpu_err_o, cmd_valid_o, resp_ready_o;
  dword_t    cpu_rdata_o, cmd_data_o;
  logic      cmd_ready_i = 1'b0;
  logic      resp_valid_i = 1'b0;
  dword_t    resp_data_i = '0;
  logic      cmd_thld_trig_o, resp_thld_trig_o;

  string     t_name[$];
  string     t_op[$];
  dword_t    t_addr[$], t_data[$], t_exp[$];
  dword_t    rx_q[$];        // Words seen leaving the command stream
  dword_t    resp_data_q[$];
  int        resp_delay_q[$];
  int        cycles = 0;
  int        cycle_limit = 200;
  int        cmd_mode = 0;   // 0 low, 1 random, 2 one pop after delay, 3 high
  int        cmd_delay = 0;
  int        cmd_seq = 0;
  int        cmd_fill = 0;   // Command words held by the DUT, from the handshakes

  hci_top DUT (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic check(input string name, input dword_t exp, input dword_t act);
    if (exp !== act) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "test failed");
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  // Controller side of the command stream
  logic [31:0] rng = 32'd22241;
  int          cur_mode = 0;
  int          cur_wait = 0;
  int          seen_seq = 0;
  always @(negedge clk_i) begin
    if (seen_seq != cmd_seq) begin
      seen_seq = cmd_seq;
      cur_mode = cmd_mode;
      cur_wait = cmd_delay;
    end
    case (cur_mode)
      0: cmd_ready_i = 1'b0;
      1: begin
        rng = xorshift32(rng);
        cmd_ready_i = rng[0];
      end
      2: begin
        if (cur_wait > 0) begin
          cur_wait = cur_wait - 1;
          cmd_ready_i = 1'b0;
        end else begin
          cmd_ready_i = 1'b1;
        end
      end
      default: cmd_ready_i = 1'b1;
    endcase
    if (cmd_valid_o && cmd_ready_i) begin  // Transfer on the coming edge
      rx_q.push_back(cmd_data_o);
      cmd_fill = cmd_fill - 1;
      if (cur_mode == 2) cur_mode = 0;   // Single pop only
    end
  end

  // Controller side of the response stream
  logic resp_fire = 1'b0;
  int   resp_wait = 0;
  always @(negedge clk_i) begin
    if (resp_fire) resp_valid_i = 1'b0;
    if (!resp_valid_i && resp_data_q.size() > 0) begin
      if (resp_wait < resp_delay_q[0]) begin
        resp_wait = resp_wait + 1;
      end else begin
        resp_data_i = resp_data_q.pop_front();
        void'(resp_delay_q.pop_front());
        resp_valid_i = 1'b1;
        resp_wait = 0;
      end
    end
    resp_fire = resp_valid_i && resp_ready_o;
  end

  task automatic cpu_access(input logic wr, input dword_t addr, input dword_t wdata,
                            output dword_t rdata, output logic err);
    @(negedge clk_i);
    cpu_req_i   = 1'b1;
    cpu_wr_i    = wr;
    cpu_addr_i  = addr[`HCI_AW-1:0];
    cpu_wdata_i = wdata;
    do @(negedge clk_i); while (!cpu_ack_o);
    rdata = cpu_rdata_o;
    err = cpu_err_o;
    cpu_req_i = 1'b0;
  endtask

  task automatic run_line(input int i);
    dword_t rdata;
    logic   err;
    dword_t word;
    case (t_op[i])
      "write", "read": begin
        cpu_access(t_op[i] == "write", t_addr[i], t_data[i], rdata, err);
        check(t_name[i], dword_t'(t_addr[i] > `HCI_A_STATUS), dword_t'(err));
        if (t_op[i] == "read") check(t_name[i], t_exp[i], rdata);
        if (t_op[i] == "read" && t_addr[i] == `HCI_A_STATUS) begin
          // Pins agree with the status bits read back
          check(t_name[i], dword_t'(t_exp[i][4]), dword_t'(cmd_thld_trig_o));
          check(t_name[i], dword_t'(t_exp[i][5]), dword_t'(resp_thld_trig_o));
          check(t_name[i], dword_t'(!t_exp[i][2]), dword_t'(resp_ready_o));
        end
        if (t_op[i] == "write" && t_addr[i] == `HCI_A_CMD) begin
          cmd_fill = cmd_fill + 1;
          if (cmd_fill > `HCI_DEPTH) begin
            stop_with_failure($sformatf("Command write in %s completed with the queue full",
                                        t_name[i]));
          end
        end
        if (t_op[i] == "write" && t_addr[i] == `HCI_A_RESET && t_data[i][0]) cmd_fill = 0;
      end
      "push_resp": begin
        resp_data_q.push_back(t_data[i]);
        resp_delay_q.push_back(int'(t_addr[i]));
        if (t_addr[i] == 0) begin  // Wait until the word is in the queue
          do @(negedge clk_i); while (resp_data_q.size() > 0 || resp_valid_i);
        end
      end
      "expect_cmd": begin
        if (t_addr[i] == 0) begin
          while (rx_q.size() == 0) @(negedge clk_i);
          word = rx_q.pop_front();
          check(t_name[i], t_exp[i], word);
        end else begin
          @(negedge clk_i);
          check(t_name[i], t_exp[i], dword_t'(cmd_valid_o));
        end
      end
      "set_cmd_ready": begin
        cmd_mode  = int'(t_data[i]);
        cmd_delay = int'(t_addr[i]);
        cmd_seq   = cmd_seq + 1;
      end
      default: stop_with_failure({"Unknown operation in test ", t_name[i]});
    endcase
  endtask

  initial begin
    int    fd;
    string line, name, op;
    dword_t a, d, e;
    fd = $fopen("sim/hci_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test vector file");
      $display("Result: FAILED");
      $fatal(1, "no vectors");
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 0 && line.getc(0) != 8'h23 &&
          $sscanf(line, "%s %s %h %h %h", name, op, a, d, e) == 5) begin
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(a);
        t_data.push_back(d);
        t_exp.push_back(e);
      end
    end
    $fclose(fd);
    cycle_limit = 200 * t_name.size() + 10;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < t_name.size(); i++) run_line(i);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: sim/hci_tests.txt
# name op addr data expected (hex); push_resp addr is a delay in cycles
# set_cmd_ready data: 0 low, 1 random, 2 one pop after addr cycles, 3 high
rst_status read 4 0 3a
rst_reset read 0 0 0
rst_thld read 1 0 0
rst_unmapped read 9 0 0
order_mode set_cmd_ready 0 1 0
order_wr0 write 2 11111111 0
order_wr1 write 2 22222222 0
order_wr2 write 2 33333333 0
order_wr3 write 2 44444444 0
order_rx0 expect_cmd 0 0 11111111
order_rx1 expect_cmd 0 0 22222222
order_rx2 expect_cmd 0 0 33333333
order_rx3 expect_cmd 0 0 44444444
resp_push0 push_resp 0 a0000001 0
resp_push1 push_resp 0 a0000002 0
resp_rd0 read 3 0 a0000001
resp_rd1 read 3 0 a0000002
resp_late push_resp 8 a0000003 0
resp_rd_wait read 3 0 a0000003
thld_mode set_cmd_ready 0 0 0
thld_wr write 1 30c 0
thld_rd read 1 0 308
thld_cmd write 2 c0000001 0
thld_status0 read 4 0 08
thld_push0 push_resp 0 b0000001 0
thld_push1 push_resp 0 b0000002 0
thld_status2 read 4 0 00
thld_push2 push_resp 0 b0000003 0
thld_status3 read 4 0 20
thld_rd0 read 3 0 b0000001
thld_rd1 read 3 0 b0000002
thld_rd2 read 3 0 b0000003
thld_clr write 1 0 0
thld_flush write 0 1 0
thld_empty read 4 0 3a
full_wr0 write 2 d0000000 0
full_wr1 write 2 d0000001 0
full_wr2 write 2 d0000002 0
full_wr3 write 2 d0000003 0
full_wr4 write 2 d0000004 0
full_wr5 write 2 d0000005 0
full_wr6 write 2 d0000006 0
full_wr7 write 2 d0000007 0
full_status read 4 0 39
full_pop_one set_cmd_ready 14 2 0
full_wr8 write 2 d0000008 0
full_first expect_cmd 0 0 d0000000
flush_wr write 0 1 0
flush_status read 4 0 3a
flush_reset read 0 0 0
flush_valid expect_cmd 1 0 0

// File: src.f
+incdir+rtl
rtl/hci_pkg.sv
rtl/hci_queue.sv
rtl/hci_csr.sv
rtl/hci_top.sv
sim/hci_props.sv
sim/hci_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := hci_tb
FLIST     := src.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
